/* gy_pkg.sv */
package gy_pkg;

    // data path width
    localparam int VERI_BIT = 32;

    // integer register address, 32 entries
    localparam int YAZMAC_BIT = 5;

    // csr address space
    localparam int CSR_ADRES_BIT = 12;

    // micro-op tag from issue
    localparam int UOP_TAG_BIT = 6;

    // program counter width
    localparam int PS_BIT = 32;

    // micro-op leaving execute
    // valid first, then pc and tag, then the two destinations
    typedef struct packed {
        logic                       gecerli;
        logic [PS_BIT-1:0]          ps;
        logic [UOP_TAG_BIT-1:0]     etiket;
        // integer destination
        logic                       rd_ayir;
        logic [YAZMAC_BIT-1:0]      rd_adres;
        logic [VERI_BIT-1:0]        rd_veri;
        // csr destination
        logic                       csr_ayir;
        logic [CSR_ADRES_BIT-1:0]   csr_adres;
        logic [VERI_BIT-1:0]        csr_veri;
    } uop_t;

    // implemented machine csrs
    localparam logic [CSR_ADRES_BIT-1:0] CSR_MTVEC    = 12'h305;
    localparam logic [CSR_ADRES_BIT-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADRES_BIT-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADRES_BIT-1:0] CSR_MCAUSE   = 12'h342;

    // warl masks, a set bit is writable
    // mtvec base is word aligned, mode bits read as direct
    localparam logic [VERI_BIT-1:0] MTVEC_MASK = 32'hFFFF_FFFC;
    // no compressed support, so mepc is word aligned too
    localparam logic [VERI_BIT-1:0] MEPC_MASK  = 32'hFFFF_FFFC;

endpackage

/* uop_yazmaci.sv */
`timescale 1ns/1ps

module uop_yazmaci (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // drop the incoming micro-op
    input  logic            flush_i,

    input  gy_pkg::uop_t    uop_i,
    output gy_pkg::uop_t    uop_o
);

    // held micro-op
    gy_pkg::uop_t uop_r;

    // payload is captured every cycle
    // only the valid bit is cleared on reset or flush
    always_ff @(posedge clk_i) begin
        uop_r <= uop_i;
        if (!rst_n_i || flush_i) begin
            uop_r.gecerli <= 1'b0;
        end
    end

    assign uop_o = uop_r;

    // a flushed op must never reach writeback
    flush_dusurur: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        flush_i |=> !uop_o.gecerli
    ) else $error("uop_yazmaci: valid micro-op after flush");

endmodule

/* geri_yaz.sv */
`timescale 1ns/1ps

module geri_yaz (
    // clock and reset only feed the checks below
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    input  gy_pkg::uop_t                        gy_uop_i,

    // integer write port
    output logic [gy_pkg::VERI_BIT-1:0]         yo_veri_o,
    output logic [gy_pkg::YAZMAC_BIT-1:0]       yo_adres_o,
    output logic [gy_pkg::UOP_TAG_BIT-1:0]      yo_etiket_o,
    output logic                                yo_gecerli_o,

    // csr write port
    output logic [gy_pkg::VERI_BIT-1:0]         csr_veri_o,
    output logic [gy_pkg::CSR_ADRES_BIT-1:0]    csr_adres_o,
    output logic [gy_pkg::UOP_TAG_BIT-1:0]      csr_etiket_o,
    output logic                                csr_gecerli_o
);

    // integer destination, qualified by uop valid
    assign yo_gecerli_o  = gy_uop_i.gecerli && gy_uop_i.rd_ayir;
    assign yo_veri_o     = gy_uop_i.rd_veri;
    assign yo_adres_o    = gy_uop_i.rd_adres;
    assign yo_etiket_o   = gy_uop_i.etiket;

    // csr destination, same qualification
    assign csr_gecerli_o = gy_uop_i.gecerli && gy_uop_i.csr_ayir;
    assign csr_veri_o    = gy_uop_i.csr_veri;
    assign csr_adres_o   = gy_uop_i.csr_adres;
    // same tag on both ports so commits pair up
    assign csr_etiket_o  = gy_uop_i.etiket;

    // write enables must be known once out of reset
    gecerli_bilinir: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown({yo_gecerli_o, csr_gecerli_o})
    ) else $error("geri_yaz: write valid is X");

    // duplicate commit guard
    // a dual-destination op must not reuse the tag of the op just before it
    cift_commit_yok: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (yo_gecerli_o && csr_gecerli_o && $past(gy_uop_i.gecerli))
            |-> (gy_uop_i.etiket != $past(gy_uop_i.etiket))
    ) else $error("geri_yaz: dual commit with repeated tag");

endmodule

/* yazmac_obegi.sv */
`timescale 1ns/1ps

module yazmac_obegi #(
    // forward the pending write to the read ports
    parameter bit BYPASS_EN = 1'b1
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // write port from writeback
    input  logic                            yaz_gecerli_i,
    input  logic [gy_pkg::YAZMAC_BIT-1:0]   yaz_adres_i,
    input  logic [gy_pkg::VERI_BIT-1:0]     yaz_veri_i,

    // two combinational read ports
    input  logic [gy_pkg::YAZMAC_BIT-1:0]   oku1_adres_i,
    input  logic [gy_pkg::YAZMAC_BIT-1:0]   oku2_adres_i,
    output logic [gy_pkg::VERI_BIT-1:0]     oku1_veri_o,
    output logic [gy_pkg::VERI_BIT-1:0]     oku2_veri_o
);

    localparam int DERINLIK = 2 ** gy_pkg::YAZMAC_BIT;
    localparam int OKU_SAYI = 2;

    logic [gy_pkg::VERI_BIT-1:0]    yazmac_r [DERINLIK];

    // read ports gathered so both share one path
    logic [gy_pkg::YAZMAC_BIT-1:0]  oku_adres [OKU_SAYI];
    logic [gy_pkg::VERI_BIT-1:0]    oku_veri  [OKU_SAYI];

    // x0 writes are dropped here
    logic                           yaz_etkin;

    assign yaz_etkin = yaz_gecerli_i && (yaz_adres_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DERINLIK; i++) begin
                yazmac_r[i] <= '0;
            end
        end else if (yaz_etkin) begin
            yazmac_r[yaz_adres_i] <= yaz_veri_i;
        end
    end

    assign oku_adres[0] = oku1_adres_i;
    assign oku_adres[1] = oku2_adres_i;

    always_comb begin
        for (int p = 0; p < OKU_SAYI; p++) begin
            if (oku_adres[p] == '0) begin
                // x0 reads zero regardless of storage
                oku_veri[p] = '0;
            end else if (BYPASS_EN && yaz_etkin && (yaz_adres_i == oku_adres[p])) begin
                // write lands next edge, show it now
                oku_veri[p] = yaz_veri_i;
            end else begin
                oku_veri[p] = yazmac_r[oku_adres[p]];
            end
        end
    end

    assign oku1_veri_o = oku_veri[0];
    assign oku2_veri_o = oku_veri[1];

    // x0 storage must never pick up a value
    x0_sifir: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        yazmac_r[0] == '0
    ) else $error("yazmac_obegi: x0 holds a nonzero value");

endmodule

/* csr_obegi.sv */
`timescale 1ns/1ps

module csr_obegi (
    input  logic                                clk_i,
    input  logic                                rst_n_i,

    // write port from writeback
    input  logic                                yaz_gecerli_i,
    input  logic [gy_pkg::CSR_ADRES_BIT-1:0]    yaz_adres_i,
    input  logic [gy_pkg::VERI_BIT-1:0]         yaz_veri_i,

    // combinational read, no bypass
    input  logic [gy_pkg::CSR_ADRES_BIT-1:0]    oku_adres_i,
    output logic [gy_pkg::VERI_BIT-1:0]         oku_veri_o
);

    // implemented machine registers
    logic [gy_pkg::VERI_BIT-1:0] mtvec_r;
    logic [gy_pkg::VERI_BIT-1:0] mscratch_r;
    logic [gy_pkg::VERI_BIT-1:0] mepc_r;
    logic [gy_pkg::VERI_BIT-1:0] mcause_r;

    // write address decode
    logic yaz_mtvec;
    logic yaz_mscratch;
    logic yaz_mepc;
    logic yaz_mcause;

    assign yaz_mtvec    = yaz_gecerli_i && (yaz_adres_i == gy_pkg::CSR_MTVEC);
    assign yaz_mscratch = yaz_gecerli_i && (yaz_adres_i == gy_pkg::CSR_MSCRATCH);
    assign yaz_mepc     = yaz_gecerli_i && (yaz_adres_i == gy_pkg::CSR_MEPC);
    assign yaz_mcause   = yaz_gecerli_i && (yaz_adres_i == gy_pkg::CSR_MCAUSE);

    // any other address decodes to nothing, so the write is lost
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mtvec_r    <= '0;
            mscratch_r <= '0;
            mepc_r     <= '0;
            mcause_r   <= '0;
        end else begin
            // warl, low bits forced to zero on the way in
            if (yaz_mtvec) begin
                mtvec_r <= yaz_veri_i & gy_pkg::MTVEC_MASK;
            end
            if (yaz_mscratch) begin
                mscratch_r <= yaz_veri_i;
            end
            if (yaz_mepc) begin
                mepc_r <= yaz_veri_i & gy_pkg::MEPC_MASK;
            end
            // full width, no legal value check on cause
            if (yaz_mcause) begin
                mcause_r <= yaz_veri_i;
            end
        end
    end

    // read mux
    always_comb begin
        case (oku_adres_i)
            gy_pkg::CSR_MTVEC:    oku_veri_o = mtvec_r;
            gy_pkg::CSR_MSCRATCH: oku_veri_o = mscratch_r;
            gy_pkg::CSR_MEPC:     oku_veri_o = mepc_r;
            gy_pkg::CSR_MCAUSE:   oku_veri_o = mcause_r;
            // unimplemented reads zero
            default:              oku_veri_o = '0;
        endcase
    end

    // mode bits of mtvec stay clear whatever was written
    mtvec_hizali: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        mtvec_r[1:0] == 2'b00
    ) else $error("csr_obegi: mtvec low bits set");

endmodule

/* geri_yaz_alt.sv */
`timescale 1ns/1ps

module geri_yaz_alt #(
    // write-to-read forwarding in the register file
    parameter bit BYPASS_EN = 1'b1
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                flush_i,

    // micro-op from execute
    input  gy_pkg::uop_t                        uop_i,

    // external read ports
    input  logic [gy_pkg::YAZMAC_BIT-1:0]       oku1_adres_i,
    input  logic [gy_pkg::YAZMAC_BIT-1:0]       oku2_adres_i,
    input  logic [gy_pkg::CSR_ADRES_BIT-1:0]    csr_oku_adres_i,
    output logic [gy_pkg::VERI_BIT-1:0]         oku1_veri_o,
    output logic [gy_pkg::VERI_BIT-1:0]         oku2_veri_o,
    output logic [gy_pkg::VERI_BIT-1:0]         csr_oku_veri_o,

    // commit observation
    output logic                                yo_gecerli_o,
    output logic [gy_pkg::UOP_TAG_BIT-1:0]      yo_etiket_o,
    output logic                                csr_gecerli_o,
    output logic [gy_pkg::UOP_TAG_BIT-1:0]      csr_etiket_o
);

    // micro-op held for writeback
    gy_pkg::uop_t                       gy_uop;

    // integer write port
    logic [gy_pkg::VERI_BIT-1:0]        yo_veri;
    logic [gy_pkg::YAZMAC_BIT-1:0]      yo_adres;

    // csr write port
    logic [gy_pkg::VERI_BIT-1:0]        csr_veri;
    logic [gy_pkg::CSR_ADRES_BIT-1:0]   csr_adres;

    uop_yazmaci u_uop_yazmaci (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .uop_i   (uop_i),
        .uop_o   (gy_uop)
    );

    // valids and tags go straight out as commit signals
    geri_yaz u_geri_yaz (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .gy_uop_i      (gy_uop),
        .yo_veri_o     (yo_veri),
        .yo_adres_o    (yo_adres),
        .yo_etiket_o   (yo_etiket_o),
        .yo_gecerli_o  (yo_gecerli_o),
        .csr_veri_o    (csr_veri),
        .csr_adres_o   (csr_adres),
        .csr_etiket_o  (csr_etiket_o),
        .csr_gecerli_o (csr_gecerli_o)
    );

    yazmac_obegi #(
        .BYPASS_EN (BYPASS_EN)
    ) u_yazmac_obegi (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .yaz_gecerli_i (yo_gecerli_o),
        .yaz_adres_i   (yo_adres),
        .yaz_veri_i    (yo_veri),
        .oku1_adres_i  (oku1_adres_i),
        .oku2_adres_i  (oku2_adres_i),
        .oku1_veri_o   (oku1_veri_o),
        .oku2_veri_o   (oku2_veri_o)
    );

    csr_obegi u_csr_obegi (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .yaz_gecerli_i (csr_gecerli_o),
        .yaz_adres_i   (csr_adres),
        .yaz_veri_i    (csr_veri),
        .oku_adres_i   (csr_oku_adres_i),
        .oku_veri_o    (csr_oku_veri_o)
    );

endmodule

/* tb_geri_yaz.sv */
`timescale 1ns/1ps

module tb_geri_yaz;

    localparam bit BYPASS = 1'b1;
    // idle cycles allowed before a dual commit must show
    localparam int COMMIT_TIMEOUT = 6;

    // named after the dut ports so the instance binds by name
    logic                               clk_i;
    logic                               rst_n_i;
    logic                               flush_i;
    gy_pkg::uop_t                       uop_i;
    logic [gy_pkg::YAZMAC_BIT-1:0]      oku1_adres_i;
    logic [gy_pkg::YAZMAC_BIT-1:0]      oku2_adres_i;
    logic [gy_pkg::CSR_ADRES_BIT-1:0]   csr_oku_adres_i;
    logic [gy_pkg::VERI_BIT-1:0]        oku1_veri_o;
    logic [gy_pkg::VERI_BIT-1:0]        oku2_veri_o;
    logic [gy_pkg::VERI_BIT-1:0]        csr_oku_veri_o;
    logic                               yo_gecerli_o;
    logic [gy_pkg::UOP_TAG_BIT-1:0]     yo_etiket_o;
    logic                               csr_gecerli_o;
    logic [gy_pkg::UOP_TAG_BIT-1:0]     csr_etiket_o;

    // shadow state, raw values as written
    logic [31:0]    rf_model [32];
    logic [31:0]    csr_model [4096];
    // op the dut holds before writeback
    gy_pkg::uop_t   pend;

    logic [31:0]    lfsr_q;
    logic [5:0]     tag_q;
    // destinations of the last two ops, reused as read addresses
    logic [4:0]     rd_hist [2];
    logic [11:0]    csr_hist [2];
    logic [11:0]    csr_list [6];
    int             checks;
    int             errors;
    int             timeouts;

    geri_yaz_alt #(.BYPASS_EN(BYPASS)) uut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // galois lfsr x^32+x^22+x^2+x+1, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // expected integer read, x0 reads zero, pending write is forwarded
    function automatic logic [31:0] expected_int_read(input logic [4:0] a);
        if (a == 5'd0) begin
            return '0;
        end
        if (BYPASS && pend.gecerli && pend.rd_ayir && pend.rd_adres == a) begin
            return pend.rd_veri;
        end
        return rf_model[a];
    endfunction

    // expected csr read, warl low bits and unimplemented addresses
    function automatic logic [31:0] expected_csr_read(input logic [11:0] a);
        case (a)
            gy_pkg::CSR_MTVEC:    return csr_model[a] & gy_pkg::MTVEC_MASK;
            gy_pkg::CSR_MEPC:     return csr_model[a] & gy_pkg::MEPC_MASK;
            gy_pkg::CSR_MSCRATCH: return csr_model[a];
            gy_pkg::CSR_MCAUSE:   return csr_model[a];
            default:              return '0;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one op per falling edge, each tag one above the last
    task automatic apply_uop(input logic v, input logic rd_ayir, input logic [4:0] rd_a,
                             input logic [31:0] rd_d, input logic csr_ayir,
                             input logic [11:0] csr_a, input logic [31:0] csr_d,
                             input logic fl);
        @(negedge clk_i);
        uop_i.gecerli   = v;
        uop_i.ps        = random_bits(32);
        uop_i.etiket    = tag_q;
        uop_i.rd_ayir   = rd_ayir;
        uop_i.rd_adres  = rd_a;
        uop_i.rd_veri   = rd_d;
        uop_i.csr_ayir  = csr_ayir;
        uop_i.csr_adres = csr_a;
        uop_i.csr_veri  = csr_d;
        flush_i         = fl;
        // one port reads the op in flight, the other the one before, swapped each op
        oku1_adres_i    = tag_q[0] ? rd_hist[1] : rd_hist[0];
        oku2_adres_i    = tag_q[0] ? rd_hist[0] : rd_hist[1];
        csr_oku_adres_i = csr_hist[1];
        rd_hist[1]      = rd_hist[0];
        rd_hist[0]      = rd_a;
        csr_hist[1]     = csr_hist[0];
        csr_hist[0]     = csr_a;
        tag_q           = tag_q + 1'b1;
    endtask

    task automatic apply_idle();
        apply_uop(1'b0, 1'b0, '0, '0, 1'b0, '0, '0, 1'b0);
    endtask

    // idle ops until both ports commit, both carry the tag that was applied
    task automatic wait_commit(input logic [5:0] tag);
        int n;
        n = 0;
        while (!(yo_gecerli_o && csr_gecerli_o) && n < COMMIT_TIMEOUT) begin
            apply_idle();
            n++;
        end
        if (yo_gecerli_o && csr_gecerli_o) begin
            check_value("dual commit int tag", yo_etiket_o, tag);
            check_value("dual commit csr tag", csr_etiket_o, tag);
        end else begin
            timeouts++;
            $display("timeout at %0t: no dual commit after %0d idle cycles", $time, n);
        end
    endtask

    // model follows each rising edge, compare half a ns before the next
    initial begin
        forever begin
            @(posedge clk_i);
            if (!rst_n_i) begin
                for (int i = 0; i < 32; i++) begin
                    rf_model[i] = '0;
                end
                for (int i = 0; i < 4096; i++) begin
                    csr_model[i] = '0;
                end
            end else if (pend.gecerli) begin
                if (pend.rd_ayir) begin
                    rf_model[pend.rd_adres] = pend.rd_veri;
                end
                if (pend.csr_ayir) begin
                    csr_model[pend.csr_adres] = pend.csr_veri;
                end
            end
            pend = uop_i;
            if (!rst_n_i || flush_i) begin
                pend.gecerli = 1'b0;
            end
            @(negedge clk_i);
            #1.5;
            if (rst_n_i) begin
                check_value("int commit valid", yo_gecerli_o, pend.gecerli && pend.rd_ayir);
                check_value("csr commit valid", csr_gecerli_o, pend.gecerli && pend.csr_ayir);
                if (pend.gecerli && pend.rd_ayir) begin
                    check_value("int commit tag", yo_etiket_o, pend.etiket);
                end
                if (pend.gecerli && pend.csr_ayir) begin
                    check_value("csr commit tag", csr_etiket_o, pend.etiket);
                end
                check_value($sformatf("read port 1 x%0d", oku1_adres_i), oku1_veri_o,
                            expected_int_read(oku1_adres_i));
                check_value($sformatf("read port 2 x%0d", oku2_adres_i), oku2_veri_o,
                            expected_int_read(oku2_adres_i));
                check_value($sformatf("csr read %h", csr_oku_adres_i), csr_oku_veri_o,
                            expected_csr_read(csr_oku_adres_i));
            end
        end
    end

    initial begin
        logic [2:0]  kind;
        logic [4:0]  a;
        logic [31:0] d;
        logic [11:0] ca;
        rst_n_i         = 1'b0;
        flush_i         = 1'b0;
        uop_i           = '0;
        oku1_adres_i    = '0;
        oku2_adres_i    = '0;
        csr_oku_adres_i = '0;
        lfsr_q          = 32'd84407;
        tag_q           = '0;
        rd_hist[0]      = '0;
        rd_hist[1]      = '0;
        csr_hist[0]     = '0;
        csr_hist[1]     = '0;
        checks          = 0;
        errors          = 0;
        timeouts        = 0;
        // four implemented csrs, then two that are not
        csr_list = '{gy_pkg::CSR_MTVEC, gy_pkg::CSR_MSCRATCH, gy_pkg::CSR_MEPC,
                     gy_pkg::CSR_MCAUSE, 12'h300, 12'h7c0};
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int n = 0; n < 400; n++) begin
            kind = random_bits(3);
            a    = random_bits(5);
            d    = random_bits(32);
            ca   = csr_list[random_bits(3) % 6];
            case (kind)
                3'd0, 3'd1, 3'd2: apply_uop(1'b1, 1'b1, a, d, 1'b0, ca, d, 1'b0);
                // integer write aimed at x0
                3'd3: apply_uop(1'b1, 1'b1, '0, d, 1'b0, ca, d, 1'b0);
                3'd4: apply_uop(1'b1, 1'b0, a, d, 1'b1, ca, d, 1'b0);
                // valid low with both allocates, or valid high with none
                3'd5: apply_uop(d[0], !d[0], a, d, !d[0], ca, d, 1'b0);
                3'd6: begin
                    apply_uop(1'b1, 1'b1, a, d, 1'b1, ca, ~d, 1'b0);
                    wait_commit(tag_q - 6'd1);
                end
                // dropped by flush, target keeps its old value
                default: apply_uop(1'b1, 1'b1, a, d, 1'b1, ca, d, 1'b1);
            endcase
        end
        apply_idle();
        apply_idle();
        @(posedge clk_i);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
gy_pkg.sv
uop_yazmaci.sv
geri_yaz.sv
yazmac_obegi.sv
csr_obegi.sv
geri_yaz_alt.sv
tb_geri_yaz.sv
